/* Bender.yml */
package:
  name: hci_bank_arbiter

export_include_dirs:
  - .

sources:
  - files:
      - hci_pkg.sv
      - bank_request_decoder.sv
      - priority_stall_regulator.sv
      - bank_grant_arbiter.sv
      - bank_request_router.sv
      - hci_bank_arbiter_top.sv

  - target: test
    files:
      - tb_hci_bank_arbiter.sv

/* bank_grant_arbiter.sv */
`timescale 1ns/1ns
`include "hci_defs.svh"

module bank_grant_arbiter (
  input  logic                                    clk,
  input  logic                                    rst,
  input  hci_pkg::bank_idx_t  [`HCI_N_LOG-1:0]    log_bank,
  input  hci_pkg::bank_mask_t [`HCI_N_LOG-1:0]    log_mask,
  input  hci_pkg::bank_mask_t                     hwpe_mask,
  input  logic                                    hwpe_wins,
  output hci_pkg::bank_mask_t                     log_conflict,
  output hci_pkg::bank_mask_t                     hwpe_conflict,
  output hci_pkg::log_mask_t                      log_gnt,
  output logic                                    hwpe_gnt,
  output hci_pkg::log_idx_t   [`HCI_N_BANKS-1:0]  bank_sel_log,
  output hci_pkg::bank_mask_t                     bank_take_log,
  output hci_pkg::bank_mask_t                     bank_take_hwpe
);

  import hci_pkg::*;

  bank_mask_t                  log_any;
  bank_mask_t [`HCI_N_LOG-1:0] log_vis;  // log requests left after hiding.
  log_idx_t [`HCI_N_BANKS-1:0] rr_ptr;
  logic                        hwpe_blocked;

  // ------------------------------------------------------------
  // log/hwpe conflict resolution
  // ------------------------------------------------------------
  always_comb begin
    log_any = '0;
    for (int m = 0; m < `HCI_N_LOG; m++) begin
      log_any = log_any | log_mask[m];
    end
  end

  assign log_conflict  = log_any;
  assign hwpe_conflict = hwpe_mask;

  // the hwpe is all or nothing, so one shared bank holds back the whole access.
  assign hwpe_blocked   = !hwpe_wins && (|(log_any & hwpe_mask));
  assign hwpe_gnt       = (|hwpe_mask) && !hwpe_blocked;
  assign bank_take_hwpe = hwpe_gnt ? hwpe_mask : '0;

  always_comb begin
    for (int m = 0; m < `HCI_N_LOG; m++) begin
      log_vis[m] = hwpe_wins ? (log_mask[m] & ~hwpe_mask) : log_mask[m];
    end
  end

  // ------------------------------------------------------------
  // per-bank round robin among log masters
  // ------------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    for (int b = 0; b < `HCI_N_BANKS; b++) begin
      found           = 1'b0;
      bank_sel_log[b] = rr_ptr[b];
      for (int k = 0; k < `HCI_N_LOG; k++) begin
        idx = (int'(rr_ptr[b]) + k) % `HCI_N_LOG;  // search starts at the pointer.
        if (!found && log_vis[idx][b]) begin
          found           = 1'b1;
          bank_sel_log[b] = log_idx_t'(idx);
        end
      end
      bank_take_log[b] = found;
    end
  end

  // a master is granted when its own bank picked it.
  always_comb begin
    for (int m = 0; m < `HCI_N_LOG; m++) begin
      log_gnt[m] = bank_take_log[log_bank[m]] &&
                   (bank_sel_log[log_bank[m]] == log_idx_t'(m));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else begin
      for (int b = 0; b < `HCI_N_BANKS; b++) begin
        if (bank_take_log[b]) begin
          rr_ptr[b] <= log_idx_t'((int'(bank_sel_log[b]) + 1) % `HCI_N_LOG);
        end
      end
    end
  end

  a_no_bank_collision : assert property (
    @(posedge clk) disable iff (rst)
    (bank_take_log & bank_take_hwpe) == '0
  ) else $error("log and hwpe were granted the same bank");

endmodule

/* bank_request_decoder.sv */
`timescale 1ns/1ns
`include "hci_defs.svh"

module bank_request_decoder (
  input  hci_pkg::log_mask_t                    log_req,
  input  hci_pkg::addr_t     [`HCI_N_LOG-1:0]   log_add,
  input  logic                                  hwpe_req,
  input  hci_pkg::addr_t                        hwpe_add,
  output hci_pkg::bank_idx_t [`HCI_N_LOG-1:0]   log_bank,
  output hci_pkg::bank_mask_t [`HCI_N_LOG-1:0]  log_mask,
  output hci_pkg::bank_mask_t                   hwpe_mask
);

  import hci_pkg::*;

  bank_idx_t hwpe_start;

  // a wide access that does not fit in the banks would alias onto itself.
  if (`HCI_HWPE_WIDTH > `HCI_N_BANKS) begin : g_width_check
    $error("HWPE width %0d exceeds bank count %0d", `HCI_HWPE_WIDTH, `HCI_N_BANKS);
  end

  // ------------------------------------------------------------
  // log side
  // ------------------------------------------------------------
  always_comb begin
    for (int m = 0; m < `HCI_N_LOG; m++) begin
      log_bank[m] = log_add[m][`HCI_BANK_LSB +: $bits(bank_idx_t)];
      if (log_req[m]) begin
        log_mask[m] = bank_mask_t'(1) << log_bank[m];
      end else begin
        log_mask[m] = '0;
      end
    end
  end

  // ------------------------------------------------------------
  // hwpe side
  // ------------------------------------------------------------
  assign hwpe_start = hwpe_add[`HCI_BANK_LSB +: $bits(bank_idx_t)];

  always_comb begin
    hwpe_mask = '0;
    for (int w = 0; w < `HCI_HWPE_WIDTH; w++) begin
      // the range wraps from the last bank back to bank 0.
      hwpe_mask[(int'(hwpe_start) + w) % `HCI_N_BANKS] = hwpe_req;
    end
  end

endmodule

/* bank_request_router.sv */
`timescale 1ns/1ns
`include "hci_defs.svh"

module bank_request_router (
  input  logic                                     clk,
  input  logic                                     rst,
  input  hci_pkg::addr_t      [`HCI_N_LOG-1:0]     log_add,
  input  hci_pkg::data_t      [`HCI_N_LOG-1:0]     log_wdata,
  input  hci_pkg::log_mask_t                       log_wen,
  input  hci_pkg::addr_t                           hwpe_add,
  input  hci_pkg::data_t      [`HCI_HWPE_WIDTH-1:0] hwpe_wdata,
  input  logic                                     hwpe_wen,
  input  hci_pkg::log_idx_t   [`HCI_N_BANKS-1:0]   bank_sel_log,
  input  hci_pkg::bank_mask_t                      bank_take_log,
  input  hci_pkg::bank_mask_t                      bank_take_hwpe,
  output hci_pkg::bank_mask_t                      bank_req,
  output hci_pkg::addr_t      [`HCI_N_BANKS-1:0]   bank_add,
  output hci_pkg::data_t      [`HCI_N_BANKS-1:0]   bank_wdata,
  output hci_pkg::bank_mask_t                      bank_wen
);

  import hci_pkg::*;

  bank_idx_t                    hwpe_start;
  addr_t [`HCI_N_BANKS-1:0]     add_next;
  data_t [`HCI_N_BANKS-1:0]     wdata_next;
  bank_mask_t                   wen_next;

  assign hwpe_start = hwpe_add[`HCI_BANK_LSB +: $bits(bank_idx_t)];

  // ------------------------------------------------------------
  // per-bank source mux
  // ------------------------------------------------------------
  always_comb begin
    int word;
    for (int b = 0; b < `HCI_N_BANKS; b++) begin
      // word offset of this bank inside the wrapped hwpe range.
      word = (b + `HCI_N_BANKS - int'(hwpe_start)) % `HCI_N_BANKS;
      if (bank_take_hwpe[b] && word < `HCI_HWPE_WIDTH) begin
        add_next[b]   = hwpe_add + addr_t'(4 * word);
        wdata_next[b] = hwpe_wdata[word];
        wen_next[b]   = hwpe_wen;
      end else begin
        add_next[b]   = log_add[bank_sel_log[b]];
        wdata_next[b] = log_wdata[bank_sel_log[b]];
        wen_next[b]   = log_wen[bank_sel_log[b]];
      end
    end
  end

  // ------------------------------------------------------------
  // output registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      bank_req <= '0;
    end else begin
      bank_req <= bank_take_log | bank_take_hwpe;
    end
  end

  always_ff @(posedge clk) begin
    bank_add   <= add_next;  // qualified by bank_req.
    bank_wdata <= wdata_next;
    bank_wen   <= wen_next;
  end

endmodule

/* hci_bank_arbiter_top.sv */
`timescale 1ns/1ns
`include "hci_defs.svh"

module hci_bank_arbiter_top #(
  parameter int unsigned STALL_MODE = `HCI_STALL_MODE
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     invert_prio,
  input  hci_pkg::stall_cnt_t                      low_prio_max_stall,
  input  hci_pkg::log_mask_t                       log_req,
  input  hci_pkg::addr_t      [`HCI_N_LOG-1:0]     log_add,
  input  hci_pkg::data_t      [`HCI_N_LOG-1:0]     log_wdata,
  input  hci_pkg::log_mask_t                       log_wen,
  output hci_pkg::log_mask_t                       log_gnt,
  input  logic                                     hwpe_req,
  input  hci_pkg::addr_t                           hwpe_add,
  input  hci_pkg::data_t      [`HCI_HWPE_WIDTH-1:0] hwpe_wdata,
  input  logic                                     hwpe_wen,
  output logic                                     hwpe_gnt,
  output hci_pkg::bank_mask_t                      bank_req,
  output hci_pkg::addr_t      [`HCI_N_BANKS-1:0]   bank_add,
  output hci_pkg::data_t      [`HCI_N_BANKS-1:0]   bank_wdata,
  output hci_pkg::bank_mask_t                      bank_wen
);

  import hci_pkg::*;

  bank_idx_t  [`HCI_N_LOG-1:0]   log_bank;
  bank_mask_t [`HCI_N_LOG-1:0]   log_mask;
  bank_mask_t                    hwpe_mask;
  bank_mask_t                    log_conflict;
  bank_mask_t                    hwpe_conflict;
  logic                          hwpe_wins;
  log_idx_t   [`HCI_N_BANKS-1:0] bank_sel_log;
  bank_mask_t                    bank_take_log;
  bank_mask_t                    bank_take_hwpe;

  // ------------------------------------------------------------
  // decode, arbitrate, regulate, route
  // ------------------------------------------------------------
  bank_request_decoder i_decoder (
    .log_req   (log_req),
    .log_add   (log_add),
    .hwpe_req  (hwpe_req),
    .hwpe_add  (hwpe_add),
    .log_bank  (log_bank),
    .log_mask  (log_mask),
    .hwpe_mask (hwpe_mask)
  );

  priority_stall_regulator #(
    .STALL_MODE (STALL_MODE)
  ) i_regulator (
    .clk                (clk),
    .rst                (rst),
    .invert_prio        (invert_prio),
    .low_prio_max_stall (low_prio_max_stall),
    .log_any            (log_conflict),
    .hwpe_any           (hwpe_conflict),
    .hwpe_wins          (hwpe_wins)
  );

  bank_grant_arbiter i_arbiter (
    .clk            (clk),
    .rst            (rst),
    .log_bank       (log_bank),
    .log_mask       (log_mask),
    .hwpe_mask      (hwpe_mask),
    .hwpe_wins      (hwpe_wins),
    .log_conflict   (log_conflict),
    .hwpe_conflict  (hwpe_conflict),
    .log_gnt        (log_gnt),
    .hwpe_gnt       (hwpe_gnt),
    .bank_sel_log   (bank_sel_log),
    .bank_take_log  (bank_take_log),
    .bank_take_hwpe (bank_take_hwpe)
  );

  bank_request_router i_router (
    .clk            (clk),
    .rst            (rst),
    .log_add        (log_add),
    .log_wdata      (log_wdata),
    .log_wen        (log_wen),
    .hwpe_add       (hwpe_add),
    .hwpe_wdata     (hwpe_wdata),
    .hwpe_wen       (hwpe_wen),
    .bank_sel_log   (bank_sel_log),
    .bank_take_log  (bank_take_log),
    .bank_take_hwpe (bank_take_hwpe),
    .bank_req       (bank_req),
    .bank_add       (bank_add),
    .bank_wdata     (bank_wdata),
    .bank_wen       (bank_wen)
  );

endmodule

/* hci_defs.svh */
`ifndef HCI_DEFS_SVH
`define HCI_DEFS_SVH

// ------------------------------------------------------------
// memory geometry
// ------------------------------------------------------------
`define HCI_N_BANKS     8
`define HCI_N_LOG       4
`define HCI_HWPE_WIDTH  4

// word-interleaved banks, so the bank index sits just above the byte offset.
`define HCI_BANK_LSB    2

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define HCI_ADDR_W      32
`define HCI_DATA_W      32
`define HCI_STALL_W     8

// 1 counts a conflict on bank overlap, 0 counts it whenever both sides ask.
`define HCI_STALL_MODE  1

`endif

/* hci_pkg.sv */
`include "hci_defs.svh"

package hci_pkg;

  // ------------------------------------------------------------
  // payload types
  // ------------------------------------------------------------
  typedef logic [`HCI_ADDR_W-1:0] addr_t;
  typedef logic [`HCI_DATA_W-1:0] data_t;

  // ------------------------------------------------------------
  // indices and masks
  // ------------------------------------------------------------
  typedef logic [$clog2(`HCI_N_BANKS)-1:0] bank_idx_t;  // address bits 4 down to 2.
  typedef logic [$clog2(`HCI_N_LOG)-1:0]   log_idx_t;   // selects one log master.
  typedef logic [`HCI_N_BANKS-1:0]         bank_mask_t;
  typedef logic [`HCI_N_LOG-1:0]           log_mask_t;

  typedef logic [`HCI_STALL_W-1:0] stall_cnt_t;

  // the swapped state lasts a single cycle and hands the win to the low side.
  typedef enum logic {
    PRIO_NORMAL,
    PRIO_SWAPPED
  } prio_state_t;

endpackage

/* priority_stall_regulator.sv */
`timescale 1ns/1ns
`include "hci_defs.svh"

module priority_stall_regulator #(
  parameter int unsigned STALL_MODE = `HCI_STALL_MODE
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                invert_prio,
  input  hci_pkg::stall_cnt_t low_prio_max_stall,
  input  hci_pkg::bank_mask_t log_any,
  input  hci_pkg::bank_mask_t hwpe_any,
  output logic                hwpe_wins
);

  import hci_pkg::*;

  prio_state_t state;
  prio_state_t state_next;
  stall_cnt_t  stall_cnt;
  stall_cnt_t  stall_cnt_next;
  logic        conflict;

  // ------------------------------------------------------------
  // conflict detection
  // ------------------------------------------------------------
  if (STALL_MODE == 1) begin : g_per_bank
    assign conflict = |(log_any & hwpe_any);  // sides meet on a bank.
  end else begin : g_global
    assign conflict = (|log_any) && (|hwpe_any);
  end

  // ------------------------------------------------------------
  // stall counter and priority FSM
  // ------------------------------------------------------------
  always_comb begin
    state_next     = PRIO_NORMAL;  // a swap never lasts past one cycle.
    stall_cnt_next = '0;
    if (state == PRIO_NORMAL && conflict) begin
      if (stall_cnt + 1'b1 >= low_prio_max_stall) begin
        state_next = PRIO_SWAPPED;
      end else begin
        stall_cnt_next = stall_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= PRIO_NORMAL;
      stall_cnt <= '0;
    end else begin
      state     <= state_next;
      stall_cnt <= stall_cnt_next;
    end
  end

  assign hwpe_wins = (state == PRIO_SWAPPED) ? !invert_prio : invert_prio;

  a_swap_one_cycle : assert property (
    @(posedge clk) disable iff (rst)
    state == PRIO_SWAPPED |=> state == PRIO_NORMAL
  ) else $error("priority stayed swapped for more than one cycle");

endmodule

/* sources.f */
+incdir+.
hci_pkg.sv
bank_request_decoder.sv
priority_stall_regulator.sv
bank_grant_arbiter.sv
bank_request_router.sv
hci_bank_arbiter_top.sv
tb_hci_bank_arbiter.sv

/* tb_hci_bank_arbiter.sv */
`timescale 1ns/1ns
`include "hci_defs.svh"

module tb_hci_bank_arbiter;

  import hci_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int STALL_OFF  = 200;  // far beyond any test length.

  // cycle budgets of reset and the six tests, plus slack for the watchdog.
  localparam int BUDGET   = 3 + 3 + 5 + 3 + 7 + 12 + 3;
  localparam int MARGIN   = 20;
  localparam int WATCHDOG = (BUDGET + MARGIN) * CLK_PERIOD;

  logic                            clk;
  logic                            rst;
  logic                            invert_prio;
  stall_cnt_t                      low_prio_max_stall;
  log_mask_t                       log_req;
  addr_t [`HCI_N_LOG-1:0]          log_add;
  data_t [`HCI_N_LOG-1:0]          log_wdata;
  log_mask_t                       log_wen;
  log_mask_t                       log_gnt;
  logic                            hwpe_req;
  addr_t                           hwpe_add;
  data_t [`HCI_HWPE_WIDTH-1:0]     hwpe_wdata;
  logic                            hwpe_wen;
  logic                            hwpe_gnt;
  bank_mask_t                      bank_req;
  addr_t [`HCI_N_BANKS-1:0]        bank_add;
  data_t [`HCI_N_BANKS-1:0]        bank_wdata;
  bank_mask_t                      bank_wen;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          lost;

  hci_bank_arbiter_top #(
    .STALL_MODE (1)
  ) UUT (
    .clk                (clk),
    .rst                (rst),
    .invert_prio        (invert_prio),
    .low_prio_max_stall (low_prio_max_stall),
    .log_req            (log_req),
    .log_add            (log_add),
    .log_wdata          (log_wdata),
    .log_wen            (log_wen),
    .log_gnt            (log_gnt),
    .hwpe_req           (hwpe_req),
    .hwpe_add           (hwpe_add),
    .hwpe_wdata         (hwpe_wdata),
    .hwpe_wen           (hwpe_wen),
    .hwpe_gnt           (hwpe_gnt),
    .bank_req           (bank_req),
    .bank_add           (bank_add),
    .bank_wdata         (bank_wdata),
    .bank_wen           (bank_wen)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  // taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // inputs change just after the edge.
  endtask

  task automatic clear_requests();
    log_req  = '0;
    hwpe_req = 1'b0;
  endtask

  // random address inside the given bank, random data and write enable.
  task automatic drive_log(input int m, input int bank);
    logic [31:0] r;
    random_bits(27, r);
    log_add[m] = {r[26:0], bank[2:0], 2'b00};
    random_bits(32, r);
    log_wdata[m] = r;
    random_bits(1, r);
    log_wen[m] = r[0];
    log_req[m] = 1'b1;
  endtask

  task automatic drive_hwpe(input int start);
    logic [31:0] r;
    random_bits(27, r);
    hwpe_add = {r[26:0], start[2:0], 2'b00};
    for (int w = 0; w < `HCI_HWPE_WIDTH; w++) begin
      random_bits(32, r);
      hwpe_wdata[w] = r;
    end
    random_bits(1, r);
    hwpe_wen = r[0];
    hwpe_req = 1'b1;
  endtask

  task automatic check_log_bank(input int m, input int b);
    check_value($sformatf("bank_req[%0d]", b), bank_req[b], 1'b1);
    check_value($sformatf("bank_add[%0d]", b), bank_add[b], log_add[m]);
    check_value($sformatf("bank_wdata[%0d]", b), bank_wdata[b], log_wdata[m]);
    check_value($sformatf("bank_wen[%0d]", b), bank_wen[b], log_wen[m]);
  endtask

  // word w lands on bank (start + w) mod banks, four bytes further on.
  task automatic check_hwpe_banks(input int start);
    int b;
    for (int w = 0; w < `HCI_HWPE_WIDTH; w++) begin
      b = (start + w) % `HCI_N_BANKS;
      check_value($sformatf("bank_add[%0d]", b), bank_add[b], hwpe_add + 4 * w);
      check_value($sformatf("bank_wdata[%0d]", b), bank_wdata[b], hwpe_wdata[w]);
      check_value($sformatf("bank_wen[%0d]", b), bank_wen[b], hwpe_wen);
    end
  endtask

  // counts the cycles the HWPE loses before its grant.
  task automatic wait_hwpe_grant(input int limit, output int lost_cycles);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < limit) begin
      @(negedge clk);
      if (hwpe_gnt) begin
        done = 1'b1;
      end else begin
        check_value("log_gnt any", |log_gnt, 1'b1);  // the log side won instead.
        n++;
        next_cycle();
      end
    end
    if (!done) begin
      errors++;
      $display("HWPE was not granted within %0d cycles at %0t ns", limit, $time);
    end
    lost_cycles = n;
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic parallel_log_test();
    drive_log(0, 1);
    drive_log(1, 3);
    drive_log(2, 4);
    drive_log(3, 6);
    @(negedge clk);
    check_value("log_gnt", log_gnt, 4'hf);
    check_value("hwpe_gnt", hwpe_gnt, 1'b0);
    next_cycle();
    clear_requests();
    @(negedge clk);
    check_value("bank_req", bank_req, 8'h5a);  // banks 1, 3, 4 and 6.
    check_log_bank(0, 1);
    check_log_bank(1, 3);
    check_log_bank(2, 4);
    check_log_bank(3, 6);
    next_cycle();
  endtask

  // all three keep asking, so only a moving pointer lets each one through.
  task automatic round_robin_test();
    drive_log(0, 5);
    drive_log(1, 5);
    drive_log(2, 5);
    for (int k = 0; k < 3; k++) begin
      @(negedge clk);
      check_value("log_gnt", log_gnt, 4'b0001 << k);
      if (k > 0) begin
        check_log_bank(k - 1, 5);
      end
      next_cycle();
    end
    clear_requests();
    @(negedge clk);
    check_log_bank(2, 5);
    next_cycle();
  endtask

  task automatic hwpe_wrap_test();
    drive_hwpe(6);
    @(negedge clk);
    check_value("hwpe_gnt", hwpe_gnt, 1'b1);
    check_value("log_gnt", log_gnt, 4'h0);
    next_cycle();
    clear_requests();
    @(negedge clk);
    check_value("bank_req", bank_req, 8'hc3);  // banks 6, 7, 0 and 1.
    check_value("bank_add[0]", bank_add[0], hwpe_add + 8);
    check_value("bank_wdata[0]", bank_wdata[0], hwpe_wdata[2]);
    check_hwpe_banks(6);
    next_cycle();
  endtask

  task automatic priority_test();
    invert_prio = 1'b0;
    drive_hwpe(2);
    drive_log(0, 4);
    @(negedge clk);
    check_value("log_gnt", log_gnt, 4'b0001);
    check_value("hwpe_gnt", hwpe_gnt, 1'b0);
    next_cycle();
    log_req[0] = 1'b0;
    @(negedge clk);
    check_value("hwpe_gnt", hwpe_gnt, 1'b1);  // the overlap is gone.
    next_cycle();
    clear_requests();

    invert_prio = 1'b1;
    drive_hwpe(2);
    drive_log(0, 4);
    @(negedge clk);
    check_value("hwpe_gnt", hwpe_gnt, 1'b1);
    check_value("log_gnt", log_gnt, 4'b0000);
    next_cycle();
    hwpe_req = 1'b0;
    @(negedge clk);
    check_value("log_gnt", log_gnt, 4'b0001);
    next_cycle();
    clear_requests();
    invert_prio = 1'b0;
  endtask

  task automatic starvation_test();
    low_prio_max_stall = 2;
    drive_hwpe(0);
    drive_log(1, 2);
    drive_log(3, 2);
    wait_hwpe_grant(8, lost);
    check_value("hwpe cycles lost", lost, 2);
    check_value("log_gnt", log_gnt, 4'b0000);
    next_cycle();
    // the HWPE asks again and priority is back with the log side.
    @(negedge clk);
    check_value("hwpe_gnt", hwpe_gnt, 1'b0);
    check_value("log_gnt any", |log_gnt, 1'b1);
    next_cycle();
    clear_requests();
    low_prio_max_stall = STALL_OFF;
  endtask

  task automatic side_by_side_test();
    drive_hwpe(4);
    drive_log(2, 1);
    @(negedge clk);
    check_value("log_gnt", log_gnt, 4'b0100);
    check_value("hwpe_gnt", hwpe_gnt, 1'b1);
    next_cycle();
    clear_requests();
    @(negedge clk);
    check_value("bank_req", bank_req, 8'hf2);
    check_log_bank(2, 1);
    check_hwpe_banks(4);
    next_cycle();
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    clk                = 1'b0;
    rst                = 1'b1;
    invert_prio        = 1'b0;
    low_prio_max_stall = STALL_OFF;
    log_req            = '0;
    log_add            = '0;
    log_wdata          = '0;
    log_wen            = '0;
    hwpe_req           = 1'b0;
    hwpe_add           = '0;
    hwpe_wdata         = '0;
    hwpe_wen           = 1'b0;
    lfsr_state         = 32'h9ca9882b;
    errors             = 0;
    checks             = 0;

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("bank_req", bank_req, 8'h00);
    next_cycle();

    parallel_log_test();
    round_robin_test();
    hwpe_wrap_test();
    priority_test();
    starvation_test();
    side_by_side_test();

    $display("Finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG);
    $display("Regression failed");
    $finish;
  end

endmodule
